/* verilog/mipsDefines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// instruction field ranges
`define OPCODE      31:26
`define SHAMT       10:6
`define FUNCT       5:0

// opcodes
`define OP_SPECIAL  6'b000000   // R-type, funct decides
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define MEM_CLASS   2'b10       // inst[31:30] of every load and store

// funct codes
// shifts: bit 0 arithmetic, bit 1 right, bit 2 variable
`define F_SLL       6'b000000
`define F_SRL       6'b000010
`define F_SRA       6'b000011
`define F_SLLV      6'b000100
`define F_SRLV      6'b000110
`define F_SRAV      6'b000111
`define F_MFHI      6'b010000
`define F_MTHI      6'b010001
`define F_MFLO      6'b010010
`define F_MTLO      6'b010011
`define F_MULT      6'b011000
`define F_MULTU     6'b011001
`define F_DIV       6'b011010
`define F_DIVU      6'b011011
`define F_ADD       6'b100000
`define F_ADDU      6'b100001
`define F_SUB       6'b100010
`define F_SUBU      6'b100011
`define F_AND       6'b100100
`define F_OR        6'b100101
`define F_XOR       6'b100110
`define F_NOR       6'b100111
`define F_SLT       6'b101010
`define F_SLTU      6'b101011

// mdCtrl bit positions
`define MD_LAUNCH    4
`define MD_DIV       3
`define MD_UNSIGNED  2
`define MD_MOVE      1
`define MD_TARGET_LO 0

// muldiv latency, cycles of busy
`define MUL_CYCLES  4
`define DIV_CYCLES  10

`endif

/* verilog/exPkg.sv */
package exPkg;

    // ALU opcode, encoding kept from the older decoder
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        NOR  = 4'd4,
        XOR  = 4'd5,
        SLL  = 4'd6,
        SRA  = 4'd7,
        SRL  = 4'd8,
        SLTU = 4'd9,
        SLT  = 4'd10,
        NONE = 4'd15    // unsupported instruction
    } aluOp;

    // operand B source
    typedef enum logic [1:0] {
        RT       = 2'd0,
        RS_SHIFT = 2'd1,    // variable shift, rs[4:0]
        SHAMT    = 2'd2,    // shamt field
        IMM      = 2'd3     // extended immediate
    } srcBSel;

    // AO result source
    typedef enum logic [1:0] {
        ALU    = 2'd0,
        FWD    = 2'd1,      // forwarded DO value
        MULDIV = 2'd2       // hi or lo
    } aoSel;

    // muldiv sequencer
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        MUL  = 2'd1,
        DIV  = 2'd2
    } mdState;

endpackage

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  exPkg::aluOp op,
    output logic [31:0] y
);
    import exPkg::*;

    logic [4:0] sh;     // shift distance

    assign sh = b[4:0];

    always_comb begin
        case (op)
            ADD:     y = a + b;    // add and addu alike
            SUB:     y = a - b;
            AND:     y = a & b;
            OR:      y = a | b;
            NOR:     y = ~(a | b);
            XOR:     y = a ^ b;
            SLL:     y = a << sh;
            SRA:     y = $unsigned($signed(a) >>> sh);  // sign fill
            SRL:     y = a >> sh;
            SLTU:    y = {31'b0, a < b};
            SLT:     y = {31'b0, $signed(a) < $signed(b)};
            default: y = '0;       // NONE
        endcase
    end

endmodule

/* verilog/exControl.sv */
`timescale 1ns/1ps
`include "mipsDefines.svh"

module exControl (
    input  logic [31:0]   inst,
    input  logic          doReliable,   // DO already holds this result
    output logic          aSel,         // rt into operand A for shifts
    output exPkg::srcBSel bSel,
    output exPkg::aoSel   resultSel,
    output exPkg::aluOp   aluCtrl,
    output logic [4:0]    mdCtrl        // {launch, divide, unsigned, move, targetLo}
);
    import exPkg::*;

    logic [5:0] funct;
    logic       special;    // R-type
    logic       shift;
    logic       immediate;
    logic       mdOp;       // any hi/lo instruction
    logic       mfHiLo;

    assign funct     = inst[`FUNCT];
    assign special   = (inst[`OPCODE] == `OP_SPECIAL);
    assign immediate = ~special;    // loads, stores and ALU immediates

    assign shift = special && (funct inside {`F_SLL, `F_SRL, `F_SRA,
                                             `F_SLLV, `F_SRLV, `F_SRAV});

    assign mdOp = special && (funct inside {`F_MULT, `F_MULTU, `F_DIV, `F_DIVU,
                                            `F_MFHI, `F_MFLO, `F_MTHI, `F_MTLO});
    assign mfHiLo = special && (funct inside {`F_MFHI, `F_MFLO});

    assign aSel = shift;

    always_comb begin
        if (shift) begin
            if (funct[2]) bSel = RS_SHIFT;  // sllv/srlv/srav
            else bSel = SHAMT;
        end else if (immediate) begin
            bSel = IMM;
        end else begin
            bSel = RT;
        end
    end

    // muldiv result beats forwarding, forwarding beats the ALU
    always_comb begin
        if (mfHiLo) resultSel = MULDIV;
        else if (doReliable) resultSel = FWD;
        else resultSel = ALU;
    end

    always_comb begin
        aluCtrl = NONE;
        if (special) begin
            case (funct)
                `F_ADD, `F_ADDU:  aluCtrl = ADD;   // no overflow trap
                `F_SUB, `F_SUBU:  aluCtrl = SUB;
                `F_AND:           aluCtrl = AND;
                `F_OR:            aluCtrl = OR;
                `F_NOR:           aluCtrl = NOR;
                `F_XOR:           aluCtrl = XOR;
                `F_SLL, `F_SLLV:  aluCtrl = SLL;
                `F_SRA, `F_SRAV:  aluCtrl = SRA;
                `F_SRL, `F_SRLV:  aluCtrl = SRL;
                `F_SLTU:          aluCtrl = SLTU;
                `F_SLT:           aluCtrl = SLT;
                default:          aluCtrl = NONE;  // muldiv ops and the rest
            endcase
        end else if (inst[31:30] == `MEM_CLASS) begin
            aluCtrl = ADD;  // address = rs + offset
        end else begin
            case (inst[`OPCODE])
                `OP_ADDI, `OP_ADDIU: aluCtrl = ADD;
                `OP_ANDI:            aluCtrl = AND;
                `OP_ORI:             aluCtrl = OR;
                `OP_XORI:            aluCtrl = XOR;
                `OP_SLTIU:           aluCtrl = SLTU;
                `OP_SLTI:            aluCtrl = SLT;
                default:             aluCtrl = NONE;
            endcase
        end
    end

    // funct regularity: bit3 launch, bit1 divide/targetLo, bit0 unsigned,
    // move when not launching and bit0 set
    assign mdCtrl = {5{mdOp}} & {inst[3], inst[1], inst[0], ~inst[3] & inst[0], inst[1]};

    // ALU table and muldiv decode never claim the same instruction
    always_comb begin
        if (aluCtrl != NONE) begin
            mdNotAlu: assert (mdCtrl == 5'b0)
                else $error("muldiv command decoded alongside an ALU operation");
        end
    end

endmodule

/* verilog/mulDivUnit.sv */
`timescale 1ns/1ps
`include "mipsDefines.svh"

module mulDivUnit (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,      // instruction accepted this cycle
    input  logic [4:0]  cmd,        // {launch, divide, unsigned, move, targetLo}
    input  logic [31:0] rs,
    input  logic [31:0] rt,
    output logic [31:0] mdResult,   // hi or lo for mfhi/mflo
    output logic        busy
);
    import exPkg::*;

    localparam int CNT_W = $clog2(`DIV_CYCLES);

    mdState             state;
    logic [CNT_W-1:0]   cnt;        // busy cycles left minus one
    logic [31:0]        hi;
    logic [31:0]        lo;
    logic [31:0]        pendHi;     // result waiting for the count
    logic [31:0]        pendLo;
    logic               launch;
    logic               move;
    logic               accept;

    logic signed [63:0] sProd;
    logic [63:0]        uProd;
    logic signed [31:0] sQuot;
    logic signed [31:0] sRem;
    logic [31:0]        uQuot;
    logic [31:0]        uRem;
    logic [63:0]        result;     // {hi, lo}

    assign launch = start & cmd[`MD_LAUNCH];
    assign move   = start & cmd[`MD_MOVE];
    assign accept = launch && (state == IDLE);
    assign busy   = (state != IDLE);

    assign mdResult = cmd[`MD_TARGET_LO] ? lo : hi;

    assign sProd = $signed(rs) * $signed(rt);   // sign extended to 64
    assign uProd = {32'b0, rs} * {32'b0, rt};
    assign sQuot = $signed(rs) / $signed(rt);
    assign sRem  = $signed(rs) % $signed(rt);   // sign of the dividend
    assign uQuot = rs / rt;
    assign uRem  = rs % rt;

    always_comb begin
        if (cmd[`MD_DIV]) begin
            // remainder to hi, quotient to lo
            if (cmd[`MD_UNSIGNED]) result = {uRem, uQuot};
            else result = {sRem, sQuot};
        end else begin
            if (cmd[`MD_UNSIGNED]) result = uProd;
            else result = $unsigned(sProd);
        end
    end

    // whole result taken at acceptance, operands may change afterwards
    always_ff @(posedge clk) begin
        if (accept) begin
            pendHi <= result[63:32];
            pendLo <= result[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
            hi    <= '0;
            lo    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (launch) begin
                        if (cmd[`MD_DIV]) begin
                            state <= DIV;
                            cnt   <= CNT_W'(`DIV_CYCLES - 1);
                        end else begin
                            state <= MUL;
                            cnt   <= CNT_W'(`MUL_CYCLES - 1);
                        end
                    end
                end
                default: begin  // MUL or DIV counting down
                    if (cnt == '0) begin
                        state <= IDLE;
                        hi    <= pendHi;   // commit as busy falls
                        lo    <= pendLo;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
            // mthi / mtlo
            if (move) begin
                if (cmd[`MD_TARGET_LO]) lo <= rs;
                else hi <= rs;
            end
        end
    end

    noIssueWhileBusy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !(start && (cmd[`MD_LAUNCH] || cmd[`MD_MOVE])))
        else $error("muldiv launch or move issued while busy");

    busyBounded: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> ##[1:`DIV_CYCLES] !busy)
        else $error("busy held longer than the divide latency");

endmodule

/* verilog/executeStage.sv */
`timescale 1ns/1ps
`include "mipsDefines.svh"

module executeStage (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] inst,
    input  logic [31:0] rsData,
    input  logic [31:0] rtData,
    input  logic [31:0] extImm,     // extended in decode
    input  logic [31:0] doData,     // forwarded DO
    input  logic        doReliable,
    input  logic        valid,
    output logic [31:0] aoData,
    output logic        aoValid,
    output logic        busy        // hold muldiv-class issue while high
);
    import exPkg::*;

    logic        aSel;
    srcBSel      bSel;
    aoSel        resultSel;
    aluOp        aluCtrl;
    logic [4:0]  mdCtrl;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluY;
    logic [31:0] mdResult;
    logic [31:0] result;    // next AO value

    exControl uCtrl (
        .inst       (inst),
        .doReliable (doReliable),
        .aSel       (aSel),
        .bSel       (bSel),
        .resultSel  (resultSel),
        .aluCtrl    (aluCtrl),
        .mdCtrl     (mdCtrl)
    );

    // shifts take rt as the value being shifted
    assign opA = aSel ? rtData : rsData;

    always_comb begin
        case (bSel)
            RS_SHIFT: opB = {27'b0, rsData[4:0]};
            SHAMT:    opB = {27'b0, inst[`SHAMT]};
            IMM:      opB = extImm;
            default:  opB = rtData;    // RT
        endcase
    end

    alu uAlu (
        .a  (opA),
        .b  (opB),
        .op (aluCtrl),
        .y  (aluY)
    );

    mulDivUnit uMulDiv (
        .clk      (clk),
        .rst      (rst),
        .start    (valid),     // cmd only counts with valid
        .cmd      (mdCtrl),
        .rs       (rsData),
        .rt       (rtData),
        .mdResult (mdResult),
        .busy     (busy)
    );

    always_comb begin
        case (resultSel)
            FWD:     result = doData;
            MULDIV:  result = mdResult;
            default: result = aluY;
        endcase
    end

    // EX/MEM register, one cycle after valid
    always_ff @(posedge clk) begin
        if (rst) aoValid <= 1'b0;
        else aoValid <= valid;
    end

    always_ff @(posedge clk) begin
        if (valid) aoData <= result;
    end

endmodule

/* verification/exStageTb.sv */
`timescale 1ns/1ps
`include "mipsDefines.svh"

module exStageTb;

    localparam int CLK_HALF     = 2;    // 4 ns period
    localparam int RESET_CYCLES = 10;
    localparam int ALU_TESTS    = 60;
    localparam int SHIFT_REPS   = 4;    // per shift form
    localparam int MEM_TESTS    = 8;
    localparam int MD_REPS      = 4;    // per mult/div form, 3 insts each
    localparam int MOVE_TESTS   = 4;    // 4 insts each
    localparam int FWD_TESTS    = 8;
    localparam int NUM_INSTS    = ALU_TESTS + 6 * SHIFT_REPS + MEM_TESTS + 4 * MD_REPS * 3
                                + MOVE_TESTS * 4 + FWD_TESTS + 2;
    localparam int WATCHDOG_NS  = NUM_INSTS * (`DIV_CYCLES + 4) * 4 + RESET_CYCLES * 4;

    localparam logic [5:0] OP_LW = 6'b100011;
    localparam logic [5:0] OP_SW = 6'b101011;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] extImm;
    logic [31:0] doData;
    logic        doReliable;
    logic        valid;
    logic [31:0] aoData;
    logic        aoValid;
    logic        busy;

    integer      seed;
    integer      errors = 0;
    logic [31:0] expQ[$];           // expected aoData, oldest first
    logic [31:0] modelHi;           // own copy of HI/LO
    logic [31:0] modelLo;
    logic        validSent;         // valid as seen at the last rising edge

    logic [5:0] aluFuncts[10] = '{`F_ADD, `F_ADDU, `F_SUB, `F_SUBU, `F_AND,
                                  `F_OR, `F_NOR, `F_XOR, `F_SLT, `F_SLTU};
    logic [5:0] immOps[7] = '{`OP_ADDI, `OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_XORI,
                              `OP_SLTI, `OP_SLTIU};
    logic [5:0] shiftFuncts[6] = '{`F_SLL, `F_SRL, `F_SRA, `F_SLLV, `F_SRLV, `F_SRAV};
    logic [5:0] mdFuncts[4] = '{`F_MULT, `F_MULTU, `F_DIV, `F_DIVU};

    executeStage dut (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .rsData     (rsData),
        .rtData     (rtData),
        .extImm     (extImm),
        .doData     (doData),
        .doReliable (doReliable),
        .valid      (valid),
        .aoData     (aoData),
        .aoValid    (aoValid),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // register fields unused, operands come in on their own ports
    function automatic logic [31:0] rType(input logic [5:0] funct, input logic [4:0] sa);
        rType = {6'b0, 5'd1, 5'd2, 5'd3, sa, funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op);
        iType = {op, 5'd1, 5'd2, 16'h0};
    endfunction

    // expected AO value for one instruction
    function automatic logic [31:0] refAo(input logic [31:0] ins, a, b, imm, fwd,
                                          input logic fwdOk, input logic [31:0] hi, lo);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] sa;
        op = ins[31:26];
        fn = ins[5:0];
        sa = ins[10:6];
        if (op == 6'b0 && fn == `F_MFHI) return hi;   // beats forwarding
        if (op == 6'b0 && fn == `F_MFLO) return lo;
        if (fwdOk) return fwd;
        if (op == 6'b0) begin
            case (fn)
                `F_ADD, `F_ADDU: return a + b;       // no trap
                `F_SUB, `F_SUBU: return a - b;
                `F_AND:  return a & b;
                `F_OR:   return a | b;
                `F_NOR:  return ~(a | b);
                `F_XOR:  return a ^ b;
                `F_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                `F_SLTU: return (a < b) ? 32'd1 : 32'd0;
                `F_SLL:  return b << sa;             // rt is the shifted value
                `F_SRL:  return b >> sa;
                `F_SRA:  return $unsigned($signed(b) >>> sa);
                `F_SLLV: return b << a[4:0];
                `F_SRLV: return b >> a[4:0];
                `F_SRAV: return $unsigned($signed(b) >>> a[4:0]);
                default: return 32'd0;    // mult, div, mthi, mtlo: nothing on the ALU path
            endcase
        end
        if (op[5:4] == 2'b10) return a + imm;       // load/store address
        case (op)
            `OP_ADDI, `OP_ADDIU: return a + imm;
            `OP_ANDI:  return a & imm;
            `OP_ORI:   return a | imm;
            `OP_XORI:  return a ^ imm;
            `OP_SLTI:  return ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
            `OP_SLTIU: return (a < imm) ? 32'd1 : 32'd0;
            default:   return 32'd0;
        endcase
    endfunction

    // HI/LO effect of mult/div/mthi/mtlo
    task automatic updateModel(input logic [31:0] ins, a, b);
        logic [63:0] prod;
        if (ins[31:26] == 6'b0) begin
            case (ins[5:0])
                `F_MULT: begin
                    prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // low 64 bits suffice
                    modelHi = prod[63:32];
                    modelLo = prod[31:0];
                end
                `F_MULTU: begin
                    prod = {32'b0, a} * {32'b0, b};
                    modelHi = prod[63:32];
                    modelLo = prod[31:0];
                end
                `F_DIV: begin
                    modelLo = $signed(a) / $signed(b);
                    modelHi = $signed(a) % $signed(b);     // dividend's sign
                end
                `F_DIVU: begin
                    modelLo = a / b;
                    modelHi = a % b;
                end
                `F_MTHI: modelHi = a;
                `F_MTLO: modelLo = a;
                default: ;
            endcase
        end
    endtask

    task automatic issue(input logic [31:0] ins, a, b, imm, fwd, input logic fwdOk);
        @(negedge clk);
        inst       = ins;
        rsData     = a;
        rtData     = b;
        extImm     = imm;
        doData     = fwd;
        doReliable = fwdOk;
        valid      = 1'b1;
        expQ.push_back(refAo(ins, a, b, imm, fwd, fwdOk, modelHi, modelLo));
        updateModel(ins, a, b);
    endtask

    task automatic idleCycle;
        @(negedge clk);
        valid      = 1'b0;
        doReliable = 1'b0;
    endtask

    // after a launch: busy must rise, then fall in bounded time
    task automatic waitMulDiv;
        int cycles;
        idleCycle();
        if (busy !== 1'b1) begin
            errors++;
            $display("busy did not rise after a multiply/divide launch at %0t", $time);
        end
        cycles = 0;
        while (busy && cycles < `DIV_CYCLES + 2) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            errors++;
            $display("busy still high %0d cycles after a launch at %0t", cycles, $time);
        end
    endtask

    // aoValid is due one edge after valid, low while in reset
    always @(posedge clk) begin
        validSent <= valid && !rst;
    end

    // comparator, outputs settled by the falling edge
    always @(negedge clk) begin
        logic [31:0] expVal;
        if (!rst) begin
            if (aoValid !== validSent) begin
                errors++;
                $display("Mismatch at %0t: aoValid expected %b got %b",
                         $time, validSent, aoValid);
            end
            if (aoValid) begin
                if (expQ.size() == 0) begin
                    errors++;
                    $display("aoValid high at %0t with no instruction outstanding", $time);
                end else begin
                    expVal = expQ.pop_front();
                    if (aoData !== expVal) begin
                        errors++;
                        $display("Mismatch at %0t: aoData expected %h got %h",
                                 $time, expVal, aoData);
                    end
                end
            end
        end
    end

    initial begin
        int          pick;
        logic [31:0] rnd;
        logic [31:0] divisor;
        seed       = 32'h3e6b2fb6;
        rst        = 1'b1;
        valid      = 1'b0;
        inst       = '0;
        rsData     = '0;
        rtData     = '0;
        extImm     = '0;
        doData     = '0;
        doReliable = 1'b0;
        modelHi    = '0;
        modelLo    = '0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (aoValid !== 1'b0 || busy !== 1'b0) begin
                errors++;
                $display("aoValid or busy not low during reset at %0t", $time);
            end
        end
        rst = 1'b0;

        // random R-type and immediate ALU ops
        repeat (ALU_TESTS) begin
            pick = $unsigned($random(seed)) % 17;
            if (pick < 10) rnd = rType(aluFuncts[pick], 5'd0);
            else rnd = iType(immOps[pick - 10]);
            issue(rnd, $random(seed), $random(seed), $random(seed), $random(seed), 1'b0);
        end

        // all six shift forms
        for (int i = 0; i < 6; i++) begin
            repeat (SHIFT_REPS) begin
                rnd = $random(seed);
                issue(rType(shiftFuncts[i], rnd[4:0]), $random(seed), $random(seed),
                      $random(seed), $random(seed), 1'b0);
            end
        end

        // loads and stores, address only
        for (int i = 0; i < MEM_TESTS; i++) begin
            issue(iType((i % 2 == 0) ? OP_LW : OP_SW), $random(seed), $random(seed),
                  $random(seed), $random(seed), 1'b0);
        end

        // mult/div forms, then read back hi and lo
        for (int i = 0; i < 4; i++) begin
            repeat (MD_REPS) begin
                rnd     = $random(seed);
                divisor = $random(seed);
                if (rnd == 0) rnd = 32'd7;
                if (divisor == 0) divisor = 32'd3;   // no divide by zero
                issue(rType(mdFuncts[i], 5'd0), rnd, divisor, '0, '0, 1'b0);
                waitMulDiv();
                issue(rType(`F_MFHI, 5'd0), $random(seed), $random(seed), '0, '0, 1'b0);
                issue(rType(`F_MFLO, 5'd0), $random(seed), $random(seed), '0, '0, 1'b0);
            end
        end

        // mthi/mtlo round trip
        repeat (MOVE_TESTS) begin
            issue(rType(`F_MTHI, 5'd0), $random(seed), $random(seed), '0, '0, 1'b0);
            issue(rType(`F_MTLO, 5'd0), $random(seed), $random(seed), '0, '0, 1'b0);
            issue(rType(`F_MFHI, 5'd0), $random(seed), $random(seed), '0, '0, 1'b0);
            issue(rType(`F_MFLO, 5'd0), $random(seed), $random(seed), '0, '0, 1'b0);
        end

        // forwarded DO value, mfhi/mflo still win
        repeat (FWD_TESTS) begin
            pick = $unsigned($random(seed)) % 10;
            issue(rType(aluFuncts[pick], 5'd0), $random(seed), $random(seed),
                  $random(seed), $random(seed), 1'b1);
        end
        issue(rType(`F_MFHI, 5'd0), $random(seed), $random(seed), '0, $random(seed), 1'b1);
        issue(rType(`F_MFLO, 5'd0), $random(seed), $random(seed), '0, $random(seed), 1'b1);

        idleCycle();
        repeat (3) @(negedge clk);
        if (expQ.size() != 0) begin
            errors++;
            $display("%0d expected results never appeared on aoData", expQ.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout, run still going after %0d ns", WATCHDOG_NS);
        $display("errors: %0d", errors + 1);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* sim.f */
+incdir+verilog
verilog/exPkg.sv
verilog/alu.sv
verilog/exControl.sv
verilog/mulDivUnit.sv
verilog/executeStage.sv
verification/exStageTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module exStageTb -f sim.f -o exStageSim

out=$(./obj_dir/exStageSim)
echo "$out"
if echo "$out" | grep -qF -- '*** PASSED ***'; then
    exit 0
fi
exit 1
